//--- mam_pkg.sv
// Debug memory access unit shared definitions
// Field widths, packet constants and FSM state encodings
package mam_pkg;

   typedef logic [15:0] flit_t;    // Debug flit payload
   typedef logic [31:0] word_t;    // Memory data word
   typedef logic [31:0] addr_t;    // Byte address
   typedef logic [13:0] beats_t;   // Burst beat count
   typedef logic [3:0]  strb_t;    // Byte strobe
   typedef logic [9:0]  mod_id_t;  // Debug module id

   localparam int MAX_PKT_LEN = 8;    // Flits per response packet
   localparam int WORD_FLITS  = 2;
   localparam int ADDR_FLITS  = 2;
   localparam int MEM_WORDS   = 256;  // Indexed by address bits 9..2

   // Sits above the module id in the response source flit
   localparam logic [5:0] SRC_PREFIX = 6'b011111;

   // Command flit fields
   localparam int CMD_RW_BIT    = 15;
   localparam int CMD_BURST_BIT = 14;

   typedef enum logic [2:0] {
      DEC_SKIP_DEST,
      DEC_SKIP_SRC,
      DEC_CMD,
      DEC_ADDR,
      DEC_DATA,
      DEC_CONT_HDR   // Header of a burst write continuation packet
   } decode_state_e;

   typedef enum logic [2:0] {
      CTRL_IDLE,
      CTRL_REQ,
      CTRL_WRITE,
      CTRL_READ,
      CTRL_DONE
   } ctrl_state_e;

endpackage

//--- mam_cmd_decode.sv
`timescale 1ns/1ps
// Debug request decoder
// Skips packet headers, collects command and address flits and
// assembles write data flit pairs into words, upper half first
module mam_cmd_decode import mam_pkg::*; (
   input  logic   clk,
   input  logic   rst,
   input  flit_t  in_data,
   input  logic   in_valid,
   input  logic   in_last,
   output logic   in_ready,
   output logic   cmd_valid,
   input  logic   cmd_ready,
   output logic   cmd_write,
   output logic   cmd_burst,
   output beats_t cmd_beats,
   output strb_t  cmd_strb,
   output addr_t  cmd_addr,
   output logic   wr_word_valid,
   input  logic   wr_word_ready,
   output word_t  wr_word
);

   decode_state_e state;
   logic   half;        // Flit index within an address or a data word
   logic   hdr_cnt;     // Continuation header flits seen
   beats_t beats_left;  // Write beats still to assemble
   beats_t flit_beats;
   flit_t  word_hi;
   logic   in_fire;
   logic   last_half;

   // Stall only while a finished command or word is not yet taken
   assign in_ready = !(cmd_valid && !cmd_ready) && !(wr_word_valid && !wr_word_ready);
   assign in_fire = in_valid && in_ready;
   assign last_half = (half == 1'(WORD_FLITS - 1));
   assign flit_beats = in_data[CMD_BURST_BIT] ? in_data[13:0] : beats_t'(1);

   always_ff @(posedge clk) begin
      if (rst) begin
         state <= DEC_SKIP_DEST;
         half <= 1'b0;
         hdr_cnt <= 1'b0;
         beats_left <= '0;
         cmd_valid <= 1'b0;
         wr_word_valid <= 1'b0;
      end else begin
         if (cmd_valid && cmd_ready)
            cmd_valid <= 1'b0;
         if (wr_word_valid && wr_word_ready)
            wr_word_valid <= 1'b0;
         if (in_fire) begin
            case (state)
               DEC_SKIP_DEST: state <= DEC_SKIP_SRC;
               DEC_SKIP_SRC:  state <= DEC_CMD;
               DEC_CMD: begin
                  beats_left <= flit_beats;
                  half <= 1'b0;
                  state <= DEC_ADDR;
               end
               DEC_ADDR: begin
                  half <= half + 1'b1;
                  if (half == 1'(ADDR_FLITS - 1)) begin
                     cmd_valid <= 1'b1;
                     if (!cmd_write)
                        state <= DEC_SKIP_DEST;
                     else if (in_last)
                        state <= DEC_CONT_HDR;  // Data follows in the next packet
                     else
                        state <= DEC_DATA;
                  end
               end
               DEC_DATA: begin
                  half <= half + 1'b1;
                  if (last_half) begin
                     wr_word_valid <= 1'b1;
                     beats_left <= beats_left - 1'b1;
                  end
                  if (last_half && beats_left == beats_t'(1))
                     state <= DEC_SKIP_DEST;
                  else if (in_last)
                     state <= DEC_CONT_HDR;
               end
               DEC_CONT_HDR: begin
                  hdr_cnt <= hdr_cnt + 1'b1;
                  if (hdr_cnt)
                     state <= DEC_DATA;
               end
               default: state <= DEC_SKIP_DEST;
            endcase
         end
      end
   end

   always_ff @(posedge clk) begin
      if (in_fire && state == DEC_CMD) begin
         cmd_write <= in_data[CMD_RW_BIT];
         cmd_burst <= in_data[CMD_BURST_BIT];
         cmd_beats <= flit_beats;
         cmd_strb <= in_data[CMD_BURST_BIT] ? 4'hf : in_data[3:0];  // Bursts write whole words
      end
      if (in_fire && state == DEC_ADDR) begin
         if (half == 1'b0)
            cmd_addr[31:16] <= in_data;
         else
            cmd_addr[15:0] <= in_data;
      end
      if (in_fire && state == DEC_DATA) begin
         if (last_half)
            wr_word <= {word_hi, in_data};
         else
            word_hi <= in_data;
      end
   end

endmodule

//--- mam_access_ctrl.sv
`timescale 1ns/1ps
// Memory access controller
// Issues one memory request per decoded command, then moves write
// beats to the memory or read beats to the response packer
module mam_access_ctrl import mam_pkg::*; (
   input  logic   clk,
   input  logic   rst,
   input  logic   cmd_valid,
   output logic   cmd_ready,
   input  logic   cmd_write,
   input  logic   cmd_burst,
   input  beats_t cmd_beats,
   input  strb_t  cmd_strb,
   input  addr_t  cmd_addr,
   input  logic   wr_word_valid,
   output logic   wr_word_ready,
   input  word_t  wr_word,
   output logic   req_valid,
   input  logic   req_ready,
   output logic   req_write,
   output addr_t  req_addr,
   output beats_t req_beats,
   output logic   write_valid,
   input  logic   write_ready,
   output word_t  write_data,
   output strb_t  write_strb,
   input  logic   read_valid,
   output logic   read_ready,
   input  word_t  read_data,
   output logic   rd_word_valid,
   input  logic   rd_word_ready,
   output word_t  rd_word,
   output logic   rd_final
);

   ctrl_state_e state;
   beats_t      remaining;  // Beats left in the current access
   logic        beat_done;
   logic        last_beat;

   assign cmd_ready = (state == CTRL_IDLE);
   assign req_valid = (state == CTRL_REQ);

   // Write beats go straight from the decoder to the memory
   assign write_valid = (state == CTRL_WRITE) && wr_word_valid;
   assign wr_word_ready = (state == CTRL_WRITE) && write_ready;
   assign write_data = wr_word;

   // Read beats go straight from the memory to the packer
   assign rd_word_valid = (state == CTRL_READ) && read_valid;
   assign read_ready = (state == CTRL_READ) && rd_word_ready;
   assign rd_word = read_data;

   assign last_beat = (remaining == beats_t'(1));
   assign rd_final = last_beat;
   assign beat_done = (write_valid && write_ready) || (rd_word_valid && rd_word_ready);

   always_ff @(posedge clk) begin
      if (rst) begin
         state <= CTRL_IDLE;
         remaining <= '0;
      end else begin
         case (state)
            CTRL_IDLE: begin
               if (cmd_valid) begin
                  remaining <= cmd_beats;
                  state <= CTRL_REQ;
               end
            end
            CTRL_REQ: begin
               if (req_ready)
                  state <= req_write ? CTRL_WRITE : CTRL_READ;
            end
            CTRL_WRITE, CTRL_READ: begin
               if (beat_done) begin
                  remaining <= remaining - 1'b1;
                  if (last_beat)
                     state <= CTRL_DONE;
               end
            end
            CTRL_DONE: state <= CTRL_IDLE;  // Lets the memory drop back to idle
            default:   state <= CTRL_IDLE;
         endcase
      end
   end

   // Request fields stay fixed for the whole access
   always_ff @(posedge clk) begin
      if (cmd_valid && cmd_ready) begin
         req_write <= cmd_write;
         req_addr <= cmd_addr;
         req_beats <= cmd_beats;
         write_strb <= cmd_burst ? 4'hf : cmd_strb;
      end
   end

endmodule

//--- mam_resp_packer.sv
`timescale 1ns/1ps
// Read response packer
// Splits read words into flits, opens each packet with a zero flit and
// a source flit, and closes it after three words or the final word
module mam_resp_packer import mam_pkg::*; (
   input  logic    clk,
   input  logic    rst,
   input  mod_id_t id,
   input  logic    rd_word_valid,
   output logic    rd_word_ready,
   input  word_t   rd_word,
   input  logic    rd_final,
   output flit_t   out_data,
   output logic    out_valid,
   input  logic    out_ready,
   output logic    out_last
);

   localparam int POS_W = $clog2(MAX_PKT_LEN);

   logic             full;     // A word is held
   logic             final_q;
   word_t            word_q;
   logic [POS_W-1:0] pos;      // Position of the next flit in the packet
   logic             lo_flit;  // Lower half of a data word
   logic             out_fire;

   assign rd_word_ready = !full;
   assign out_valid = full;
   assign out_fire = out_valid && out_ready;

   // Data flits start at position 2, upper halves sit at even positions
   assign lo_flit = pos[0] && (pos != POS_W'(1));
   assign out_last = full && lo_flit && ((pos == POS_W'(MAX_PKT_LEN - 1)) || final_q);

   always_comb begin
      if (pos == '0)
         out_data = '0;
      else if (pos == POS_W'(1))
         out_data = {SRC_PREFIX, id};
      else if (lo_flit)
         out_data = word_q[15:0];
      else
         out_data = word_q[31:16];
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         full <= 1'b0;
         pos <= '0;
      end else begin
         if (rd_word_valid && rd_word_ready)
            full <= 1'b1;
         else if (out_fire && lo_flit)
            full <= 1'b0;
         if (out_fire)
            pos <= out_last ? '0 : pos + 1'b1;  // Next word opens a new packet
      end
   end

   always_ff @(posedge clk) begin
      if (rd_word_valid && rd_word_ready) begin
         word_q <= rd_word;
         final_q <= rd_final;
      end
   end

endmodule

//--- mam_mem.sv
`timescale 1ns/1ps
// On-chip word memory with request, write and read channels
// Synchronous read, byte strobes on writes, address wraps at the top
module mam_mem import mam_pkg::*; (
   input  logic   clk,
   input  logic   rst,
   input  logic   req_valid,
   output logic   req_ready,
   input  logic   req_write,
   input  addr_t  req_addr,
   input  beats_t req_beats,
   input  logic   write_valid,
   output logic   write_ready,
   input  word_t  write_data,
   input  strb_t  write_strb,
   output logic   read_valid,
   input  logic   read_ready,
   output word_t  read_data
);

   localparam int IDX_W = $clog2(MEM_WORDS);

   word_t            mem [MEM_WORDS];
   logic             busy;
   logic             writing;
   logic [IDX_W-1:0] ptr;       // Current word index
   logic [IDX_W-1:0] next_ptr;
   beats_t           cnt;       // Beats left
   logic             req_fire;
   logic             wr_fire;
   logic             rd_fire;

   assign req_ready = !busy;
   assign write_ready = busy && writing;
   assign read_valid = busy && !writing;  // Data already fetched one cycle ahead
   assign req_fire = req_valid && req_ready;
   assign wr_fire = write_valid && write_ready;
   assign rd_fire = read_valid && read_ready;
   assign next_ptr = ptr + 1'b1;

   always_ff @(posedge clk) begin
      if (rst) begin
         busy <= 1'b0;
         writing <= 1'b0;
         ptr <= '0;
         cnt <= '0;
      end else if (req_fire) begin
         busy <= 1'b1;
         writing <= req_write;
         ptr <= req_addr[IDX_W+1:2];
         cnt <= req_beats;
      end else if (wr_fire || rd_fire) begin
         ptr <= next_ptr;
         cnt <= cnt - 1'b1;
         if (cnt == beats_t'(1))
            busy <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (wr_fire) begin
         for (int i = 0; i < 4; i++) begin
            if (write_strb[i])
               mem[ptr][i*8 +: 8] <= write_data[i*8 +: 8];
         end
      end
      if (req_fire)
         read_data <= mem[req_addr[IDX_W+1:2]];
      else if (rd_fire)
         read_data <= mem[next_ptr];  // Prefetch the next beat
   end

endmodule

//--- mam_top.sv
`timescale 1ns/1ps
// Debug memory access unit top level
// Request decoder, access controller, response packer and memory
module mam_top import mam_pkg::*; (
   input  logic    clk,
   input  logic    rst,
   input  mod_id_t id,
   input  flit_t   in_data,
   input  logic    in_valid,
   input  logic    in_last,
   output logic    in_ready,
   output flit_t   out_data,
   output logic    out_valid,
   input  logic    out_ready,
   output logic    out_last
);

   logic   cmd_valid;
   logic   cmd_ready;
   logic   cmd_write;
   logic   cmd_burst;
   beats_t cmd_beats;
   strb_t  cmd_strb;
   addr_t  cmd_addr;
   logic   wr_word_valid;
   logic   wr_word_ready;
   word_t  wr_word;
   logic   req_valid;
   logic   req_ready;
   logic   req_write;
   addr_t  req_addr;
   beats_t req_beats;
   logic   write_valid;
   logic   write_ready;
   word_t  write_data;
   strb_t  write_strb;
   logic   read_valid;
   logic   read_ready;
   word_t  read_data;
   logic   rd_word_valid;
   logic   rd_word_ready;
   word_t  rd_word;
   logic   rd_final;

   mam_cmd_decode u_decode (
      .clk(clk), .rst(rst),
      .in_data(in_data), .in_valid(in_valid), .in_last(in_last), .in_ready(in_ready),
      .cmd_valid(cmd_valid), .cmd_ready(cmd_ready), .cmd_write(cmd_write),
      .cmd_burst(cmd_burst), .cmd_beats(cmd_beats), .cmd_strb(cmd_strb),
      .cmd_addr(cmd_addr),
      .wr_word_valid(wr_word_valid), .wr_word_ready(wr_word_ready), .wr_word(wr_word)
   );

   mam_access_ctrl u_ctrl (
      .clk(clk), .rst(rst),
      .cmd_valid(cmd_valid), .cmd_ready(cmd_ready), .cmd_write(cmd_write),
      .cmd_burst(cmd_burst), .cmd_beats(cmd_beats), .cmd_strb(cmd_strb),
      .cmd_addr(cmd_addr),
      .wr_word_valid(wr_word_valid), .wr_word_ready(wr_word_ready), .wr_word(wr_word),
      .req_valid(req_valid), .req_ready(req_ready), .req_write(req_write),
      .req_addr(req_addr), .req_beats(req_beats),
      .write_valid(write_valid), .write_ready(write_ready),
      .write_data(write_data), .write_strb(write_strb),
      .read_valid(read_valid), .read_ready(read_ready), .read_data(read_data),
      .rd_word_valid(rd_word_valid), .rd_word_ready(rd_word_ready),
      .rd_word(rd_word), .rd_final(rd_final)
   );

   mam_resp_packer u_packer (
      .clk(clk), .rst(rst), .id(id),
      .rd_word_valid(rd_word_valid), .rd_word_ready(rd_word_ready),
      .rd_word(rd_word), .rd_final(rd_final),
      .out_data(out_data), .out_valid(out_valid), .out_ready(out_ready),
      .out_last(out_last)
   );

   mam_mem u_mem (
      .clk(clk), .rst(rst),
      .req_valid(req_valid), .req_ready(req_ready), .req_write(req_write),
      .req_addr(req_addr), .req_beats(req_beats),
      .write_valid(write_valid), .write_ready(write_ready),
      .write_data(write_data), .write_strb(write_strb),
      .read_valid(read_valid), .read_ready(read_ready), .read_data(read_data)
   );

endmodule

//--- mam_assertions.sv
`timescale 1ns/1ps
// Protocol checks on the response flit stream
module mam_assertions import mam_pkg::*; (
   input logic  clk,
   input logic  rst,
   input flit_t out_data,
   input logic  out_valid,
   input logic  out_ready,
   input logic  out_last
);

   int fail_count = 0;

   // Stalled flit must not change
   out_hold: assert property (@(posedge clk) disable iff (rst)
      out_valid && !out_ready |=> out_valid && $stable(out_data) && $stable(out_last))
      else begin
         $error("out flit changed while stalled");
         fail_count++;
      end

   out_reset: assert property (@(posedge clk) rst |=> !out_valid)
      else begin
         $error("out_valid high after reset");
         fail_count++;
      end

   last_valid: assert property (@(posedge clk) disable iff (rst) out_last |-> out_valid)
      else begin
         $error("out_last without out_valid");
         fail_count++;
      end

endmodule

bind mam_top mam_assertions u_assert (
   .clk(clk), .rst(rst),
   .out_data(out_data), .out_valid(out_valid), .out_ready(out_ready), .out_last(out_last)
);

//--- tb_mam.sv
`timescale 1ns/1ps
// Testbench for the debug memory access unit
// Sends request packets with random gaps, predicts read responses from a
// shadow memory and checks every output flit
module tb_mam import mam_pkg::*; ();

   localparam int CLK_PERIOD = 100;
   localparam int TOTAL_FLITS = 320;  // Request and response flits of all tests, rounded up
   localparam mod_id_t MOD_ID = 10'h2a5;

   logic    clk;
   logic    rst;
   mod_id_t id;
   flit_t   in_data;
   logic    in_valid;
   logic    in_last;
   logic    in_ready;
   flit_t   out_data;
   logic    out_valid;
   logic    out_ready;
   logic    out_last;

   integer seed;
   logic   bp_on;              // Random stalls on out_ready
   int     data_errors = 0;
   int     last_errors = 0;
   int     other_errors = 0;
   int     reset_errors = 0;
   int     flit_count = 0;
   string  test_name;
   word_t  shadow [MEM_WORDS];
   flit_t  pkt [$];
   flit_t  exp_data [$];
   logic   exp_last [$];
   flit_t  exp_flit;
   logic   exp_flag;

   mam_top uut (
      .clk(clk), .rst(rst), .id(id),
      .in_data(in_data), .in_valid(in_valid), .in_last(in_last), .in_ready(in_ready),
      .out_data(out_data), .out_valid(out_valid), .out_ready(out_ready),
      .out_last(out_last)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   // Byte lanes with a set strobe bit take the new data
   function automatic word_t merge_word(word_t old_word, word_t new_word, strb_t strb);
      word_t result;
      result = old_word;
      for (int b = 0; b < 4; b++) begin
         if (strb[b])
            result[b*8 +: 8] = new_word[b*8 +: 8];
      end
      return result;
   endfunction

   // Word hit by a beat, address bits 9..2 wrap at the top
   function automatic int word_index(addr_t addr, int beat);
      return (int'(addr[9:2]) + beat) % MEM_WORDS;
   endfunction

   task automatic start_packet(flit_t cmd, addr_t addr);
      pkt.delete();
      pkt.push_back(16'h0000);  // Destination
      pkt.push_back(16'h1000);  // Source and type
      pkt.push_back(cmd);
      pkt.push_back(addr[31:16]);
      pkt.push_back(addr[15:0]);
   endtask

   task automatic send_packet();
      int gap;
      for (int i = 0; i < pkt.size(); i++) begin
         gap = $unsigned($random(seed)) % 3;
         repeat (gap) begin
            @(posedge clk);
            #1;
         end
         in_data = pkt[i];
         in_valid = 1'b1;
         in_last = (i == pkt.size() - 1);
         @(negedge clk);
         while (!in_ready)
            @(negedge clk);
         @(posedge clk);  // Flit taken here
         #1;
         in_valid = 1'b0;
         in_last = 1'b0;
      end
   endtask

   task automatic write_single(addr_t addr, word_t data, strb_t strb);
      start_packet({2'b10, 10'h000, strb}, addr);
      pkt.push_back(data[31:16]);
      pkt.push_back(data[15:0]);
      send_packet();
      shadow[word_index(addr, 0)] = merge_word(shadow[word_index(addr, 0)], data, strb);
   endtask

   // Random words; beats past split go into a continuation packet
   task automatic write_burst(addr_t addr, int beats, int split);
      word_t data;
      start_packet({2'b11, beats_t'(beats)}, addr);
      for (int k = 0; k < beats; k++) begin
         if (k == split) begin
            send_packet();
            pkt.delete();
            pkt.push_back(16'h0000);
            pkt.push_back(16'h1000);
         end
         data = $random(seed);
         pkt.push_back(data[31:16]);
         pkt.push_back(data[15:0]);
         shadow[word_index(addr, k)] = merge_word(shadow[word_index(addr, k)], data, 4'hf);
      end
      send_packet();
   endtask

   // Three words per response packet, each packet opened by two header flits
   task automatic read_words(addr_t addr, int beats);
      word_t w;
      logic  burst;
      burst = (beats > 1);
      start_packet({1'b0, burst, beats_t'(beats)}, addr);
      for (int k = 0; k < beats; k++) begin
         w = shadow[word_index(addr, k)];
         if (k % 3 == 0) begin
            exp_data.push_back(16'h0000);
            exp_last.push_back(1'b0);
            exp_data.push_back({SRC_PREFIX, MOD_ID});
            exp_last.push_back(1'b0);
         end
         exp_data.push_back(w[31:16]);
         exp_last.push_back(1'b0);
         exp_data.push_back(w[15:0]);
         exp_last.push_back(k % 3 == 2 || k == beats - 1);
      end
      send_packet();
      while (exp_data.size() != 0)
         @(posedge clk);
      #1;
   endtask

   initial begin
      out_ready = 1'b1;
      forever begin
         @(posedge clk);
         #1;
         out_ready = bp_on ? ($random(seed) % 3 != 0) : 1'b1;
      end
   end

   // Handshake seen at the falling edge completes on the next rising edge
   always @(negedge clk) begin
      if (!rst && out_valid && out_ready) begin
         flit_count++;
         if (exp_data.size() == 0) begin
            $display("Output flit %h arrived during %s with no read pending",
                     out_data, test_name);
            other_errors++;
         end else begin
            exp_flit = exp_data.pop_front();
            exp_flag = exp_last.pop_front();
            if (out_data !== exp_flit) begin
               $display("error %s: flit expected %h actual %h", test_name, exp_flit, out_data);
               data_errors++;
            end
            if (out_last !== exp_flag) begin
               $display("error %s: last expected %b actual %b", test_name, exp_flag, out_last);
               last_errors++;
            end
         end
      end
   end

   initial begin
      repeat (TOTAL_FLITS * 20) @(posedge clk);
      $display("Timeout: the tests did not finish within %0d cycles", TOTAL_FLITS * 20);
      $display("Some tests failed");
      $finish;
   end

   initial begin
      seed = 20601;
      bp_on = 1'b0;
      test_name = "reset";
      rst = 1'b1;
      id = MOD_ID;
      in_data = '0;
      in_valid = 1'b0;
      in_last = 1'b0;
      repeat (5) @(posedge clk);
      #1;
      rst = 1'b0;
      @(negedge clk);
      if (out_valid !== 1'b0 || in_ready !== 1'b1) begin
         $display("After reset out_valid is %b and in_ready is %b, not low and high",
                  out_valid, in_ready);
         reset_errors++;
      end
      @(posedge clk);
      #1;

      test_name = "strobe_merge";
      write_single(32'h0000_0040, 32'h1122_3344, 4'hf);
      write_single(32'h0000_0040, 32'haabb_ccdd, 4'b0101);
      read_words(32'h0000_0040, 1);

      test_name = "burst4";
      write_burst(32'h0000_0100, 4, 4);
      read_words(32'h0000_0100, 4);

      test_name = "split_burst5";
      write_burst(32'h0000_0200, 5, 3);
      read_words(32'h0000_0200, 5);

      test_name = "burst10_read";
      write_burst(32'h0000_0300, 10, 10);
      read_words(32'h0000_0300, 10);

      test_name = "backpressure";
      write_burst(32'h0000_0140, 12, 12);
      read_words(32'h0000_0140, 12);
      bp_on = 1'b1;
      read_words(32'h0000_0140, 12);  // Same flits expected as the unstalled read
      bp_on = 1'b0;

      test_name = "wrap";
      write_burst(32'h0000_03f8, 4, 4);
      read_words(32'h0000_03f8, 4);
      read_words(32'h0000_1000, 2);   // Aliases word zero

      repeat (10) @(posedge clk);
      $display("Compared %0d flits: %0d data, %0d last, %0d other, %0d reset, %0d assertion errors",
               flit_count, data_errors, last_errors, other_errors, reset_errors,
               uut.u_assert.fail_count);
      if (data_errors + last_errors + other_errors + reset_errors
          + uut.u_assert.fail_count == 0)
         $display("All tests passed");
      else
         $display("Some tests failed");
      $finish;
   end

endmodule

//--- tb.f
mam_pkg.sv
mam_cmd_decode.sv
mam_access_ctrl.sv
mam_resp_packer.sv
mam_mem.sv
mam_top.sv
mam_assertions.sv
tb_mam.sv

//--- run.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and looks for the pass message
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module tb_mam -f tb.f -o tb_mam_sim
result=$(./obj_dir/tb_mam_sim 2>&1 || true)
echo "$result"
grep -qx "All tests passed" <<< "$result"
